// File: verilog.f
hw/csr_pkg.sv
hw/csr_wr_if.sv
hw/csr_exc_state.sv
hw/csr_timer.sv
hw/csr_save_slot.sv
hw/csr_read_mux.sv
hw/csr_regfile.sv
bench/csr_checker.sv
bench/tb_csr.sv

// File: run.sh
#!/bin/sh
# Build and run with Verilator, then judge the run by its log
verilator --binary --timing --timescale 1ns/10ps --top-module tb_csr \
    -f verilog.f -o csr_sim > build.log 2>&1 \
    && ./obj_dir/csr_sim > sim.log 2>&1 \
    || { cat build.log; echo "Build or run error"; exit 1; }
cat sim.log
grep -q "sim failed" sim.log && exit 1 || exit 0

// File: bench/tb_csr.sv
`timescale 1ns/10ps

module tb_csr import csr_pkg::*; ();

    typedef enum logic [3:0] {
        OP_WR, OP_RD, OP_ENT, OP_RET, OP_EXC, OP_ERTN, OP_IDLE, OP_POLL, OP_PINT
    } op_t;

    typedef struct packed {
        op_t                   op;
        logic [CSR_ADDR_W-1:0] addr;
        csr_word_t             mask;
        csr_word_t             data;
        logic [14:0]           code;
        csr_word_t             pc;
        csr_word_t             want;
        logic                  want_int;
    } step_t;

    localparam csr_word_t             ALL        = '1;
    localparam logic [CSR_ADDR_W-1:0] NO_ADDR    = '0;
    localparam logic [CSR_ADDR_W-1:0] BAD_ADDR   = 14'h3FF;
    localparam int                    POLL_LIMIT = 50;
    localparam int unsigned           SEED       = 32'h80b5_a557;

    logic                  clk;
    logic                  resetn;
    logic                  csr_we;
    logic [CSR_ADDR_W-1:0] csr_waddr;
    csr_word_t             csr_wmask;
    csr_word_t             csr_wdata;
    logic [CSR_ADDR_W-1:0] csr_raddr;
    csr_word_t             csr_rdata;
    logic                  wb_exc;
    logic [ECODE_W-1:0]    wb_ecode;
    logic [ESUBCODE_W-1:0] wb_esubcode;
    csr_word_t             wb_pc;
    logic                  ertn_flush;
    logic                  has_int;
    csr_word_t             exc_entaddr;
    csr_word_t             exc_retaddr;

    logic       check;
    logic [1:0] kind;
    int         step_no;
    csr_word_t  want;
    csr_word_t  want_mask;
    logic       want_int;
    int         passes;
    int         fails;
    int         timeouts = 0;

    step_t steps[$];

    csr_regfile i_csr_regfile (
        .clk         (clk),
        .resetn      (resetn),
        .csr_we      (csr_we),
        .csr_waddr   (csr_waddr),
        .csr_wmask   (csr_wmask),
        .csr_wdata   (csr_wdata),
        .csr_raddr   (csr_raddr),
        .csr_rdata   (csr_rdata),
        .wb_exc      (wb_exc),
        .wb_ecode    (wb_ecode),
        .wb_esubcode (wb_esubcode),
        .wb_pc       (wb_pc),
        .ertn_flush  (ertn_flush),
        .has_int     (has_int),
        .exc_entaddr (exc_entaddr),
        .exc_retaddr (exc_retaddr)
    );

    csr_checker i_checker (
        .clk       (clk),
        .check     (check),
        .kind      (kind),
        .step_no   (step_no),
        .want      (want),
        .want_mask (want_mask),
        .want_int  (want_int),
        .rdata     (csr_rdata),
        .entaddr   (exc_entaddr),
        .retaddr   (exc_retaddr),
        .has_int   (has_int),
        .passes    (passes),
        .fails     (fails)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic void add_step(op_t op, logic [CSR_ADDR_W-1:0] addr, csr_word_t mask,
                                     csr_word_t data, csr_word_t want_val, logic int_val);
        step_t s;
        s = '{op: op, addr: addr, mask: mask, data: data, code: '0, pc: '0,
              want: want_val, want_int: int_val};
        steps.push_back(s);
    endfunction

    function automatic void add_exception(logic [ESUBCODE_W-1:0] esub,
                                          logic [ECODE_W-1:0] ecode, csr_word_t pc);
        step_t s;
        s = '{op: OP_EXC, addr: NO_ADDR, mask: '0, data: '0, code: {esub, ecode}, pc: pc,
              want: '0, want_int: 1'b0};
        steps.push_back(s);
    endfunction

    function automatic void build_table();
        csr_word_t first [SAVE_COUNT];
        csr_word_t smask [SAVE_COUNT];
        csr_word_t sdata [SAVE_COUNT];
        for (int i = 0; i < SAVE_COUNT; i++) begin
            first[i] = $urandom();
            smask[i] = $urandom();
            sdata[i] = $urandom();
        end
        // Reset values
        add_step(OP_RD, CSR_CRMD, ALL, '0, 32'h0000_0008, 1'b0);
        add_step(OP_RD, CSR_PRMD, ALL, '0, 32'h0, 1'b0);
        add_step(OP_RD, CSR_ECFG, ALL, '0, 32'h0, 1'b0);
        add_step(OP_RD, CSR_ESTAT, ALL, '0, 32'h0, 1'b0);
        add_step(OP_RD, CSR_ERA, ALL, '0, 32'h0, 1'b0);
        add_step(OP_RD, CSR_EENTRY, ALL, '0, 32'h0, 1'b0);
        add_step(OP_RD, CSR_TCFG, ALL, '0, 32'h0, 1'b0);
        add_step(OP_RD, CSR_TVAL, ALL, '0, 32'hFFFF_FFFF, 1'b0);
        add_step(OP_RD, CSR_TICLR, ALL, '0, 32'h0, 1'b0);
        add_step(OP_RD, BAD_ADDR, ALL, '0, 32'h0, 1'b0);
        for (int i = 0; i < SAVE_COUNT; i++)
            add_step(OP_RD, CSR_SAVE_BASE + CSR_ADDR_W'(i), ALL, '0, 32'h0, 1'b0);
        add_step(OP_ENT, NO_ADDR, ALL, '0, 32'h0, 1'b0);
        add_step(OP_RET, NO_ADDR, ALL, '0, 32'h0, 1'b0);
        // Scratch slots take a full write then a partial one
        for (int i = 0; i < SAVE_COUNT; i++)
            add_step(OP_WR, CSR_SAVE_BASE + CSR_ADDR_W'(i), ALL, first[i], '0, 1'b0);
        for (int i = 0; i < SAVE_COUNT; i++)
            add_step(OP_WR, CSR_SAVE_BASE + CSR_ADDR_W'(i), smask[i], sdata[i], '0, 1'b0);
        for (int i = 0; i < SAVE_COUNT; i++)
            add_step(OP_RD, CSR_SAVE_BASE + CSR_ADDR_W'(i), ALL, '0,
                     (sdata[i] & smask[i]) | (first[i] & ~smask[i]), 1'b0);
        add_step(OP_WR, CSR_ERA, ALL, 32'h1234_5678, '0, 1'b0);
        add_step(OP_WR, CSR_ERA, 32'hFFFF_0000, 32'hABCD_0000, '0, 1'b0);
        add_step(OP_RD, CSR_ERA, ALL, '0, 32'hABCD_5678, 1'b0);
        add_step(OP_RET, NO_ADDR, ALL, '0, 32'hABCD_5678, 1'b0);
        add_step(OP_WR, CSR_EENTRY, ALL, 32'h8000_1FFF, '0, 1'b0);
        add_step(OP_RD, CSR_EENTRY, ALL, '0, 32'h8000_1FC0, 1'b0);
        add_step(OP_WR, CSR_EENTRY, 32'hFFFF_0000, 32'h1C00_0000, '0, 1'b0);
        add_step(OP_RD, CSR_EENTRY, ALL, '0, 32'h1C00_1FC0, 1'b0);
        add_step(OP_ENT, NO_ADDR, ALL, '0, 32'h1C00_1FC0, 1'b0);
        add_step(OP_WR, CSR_ECFG, ALL, ALL, '0, 1'b0);
        add_step(OP_RD, CSR_ECFG, ALL, '0, 32'h0000_1FFF, 1'b0);
        add_step(OP_WR, CSR_ECFG, 32'h0000_1000, 32'h0, '0, 1'b0);
        add_step(OP_RD, CSR_ECFG, ALL, '0, 32'h0000_0FFF, 1'b0);
        add_step(OP_WR, CSR_ECFG, ALL, 32'h0, '0, 1'b0);
        add_step(OP_WR, CSR_PRMD, ALL, ALL, '0, 1'b0);
        add_step(OP_RD, CSR_PRMD, ALL, '0, 32'h0000_0007, 1'b0);
        add_step(OP_WR, CSR_PRMD, 32'h0000_0003, 32'h0000_0001, '0, 1'b0);
        add_step(OP_RD, CSR_PRMD, ALL, '0, 32'h0000_0005, 1'b0);
        // DA and PG are constants
        add_step(OP_WR, CSR_CRMD, ALL, ALL, '0, 1'b0);
        add_step(OP_RD, CSR_CRMD, ALL, '0, 32'h0000_000F, 1'b0);
        // Exception entry and return
        add_exception(9'h1A5, 6'h0B, 32'h1C00_0ABC);
        add_step(OP_RD, CSR_CRMD, ALL, '0, 32'h0000_0008, 1'b0);
        add_step(OP_RD, CSR_PRMD, ALL, '0, 32'h0000_0007, 1'b0);
        add_step(OP_RD, CSR_ESTAT, ALL, '0, 32'h694B_0000, 1'b0);
        add_step(OP_RD, CSR_ERA, ALL, '0, 32'h1C00_0ABC, 1'b0);
        add_step(OP_RET, NO_ADDR, ALL, '0, 32'h1C00_0ABC, 1'b0);
        add_step(OP_ERTN, NO_ADDR, '0, '0, '0, 1'b0);
        add_step(OP_RD, CSR_CRMD, ALL, '0, 32'h0000_000F, 1'b0);
        // One-shot timer with initval 2
        add_step(OP_WR, CSR_TCFG, ALL, 32'h0000_0009, '0, 1'b0);
        add_step(OP_RD, CSR_TVAL, ALL, '0, 32'h0000_0008, 1'b0);
        add_step(OP_RD, CSR_TVAL, ALL, '0, 32'h0000_0007, 1'b0);
        add_step(OP_RD, CSR_TVAL, ALL, '0, 32'h0000_0006, 1'b0);
        add_step(OP_POLL, CSR_ESTAT, 32'h0000_0800, '0, 32'h0000_0800, 1'b0);
        add_step(OP_RD, CSR_TVAL, ALL, '0, 32'hFFFF_FFFF, 1'b0);
        add_step(OP_IDLE, NO_ADDR, '0, 32'd5, '0, 1'b0);
        add_step(OP_RD, CSR_TVAL, ALL, '0, 32'hFFFF_FFFF, 1'b0);
        add_step(OP_RD, CSR_TCFG, ALL, '0, 32'h0000_0009, 1'b0);
        add_step(OP_WR, CSR_TICLR, ALL, 32'h0000_0001, '0, 1'b0);
        add_step(OP_RD, CSR_ESTAT, ALL, '0, 32'h694B_0000, 1'b0);
        // Periodic timer with initval 1
        add_step(OP_WR, CSR_TCFG, ALL, 32'h0000_0007, '0, 1'b0);
        add_step(OP_RD, CSR_TVAL, ALL, '0, 32'h0000_0004, 1'b0);
        add_step(OP_RD, CSR_TVAL, ALL, '0, 32'h0000_0003, 1'b0);
        add_step(OP_RD, CSR_TVAL, ALL, '0, 32'h0000_0002, 1'b0);
        add_step(OP_RD, CSR_TVAL, ALL, '0, 32'h0000_0001, 1'b0);
        add_step(OP_RD, CSR_TVAL, ALL, '0, 32'h0000_0000, 1'b0);
        add_step(OP_RD, CSR_TVAL, ALL, '0, 32'h0000_0004, 1'b0);
        add_step(OP_RD, CSR_ESTAT, ALL, '0, 32'h694B_0800, 1'b0);
        add_step(OP_WR, CSR_TICLR, ALL, 32'h0000_0001, '0, 1'b0);
        add_step(OP_RD, CSR_ESTAT, ALL, '0, 32'h694B_0000, 1'b0);
        add_step(OP_POLL, CSR_ESTAT, 32'h0000_0800, '0, 32'h0000_0800, 1'b0);
        add_step(OP_WR, CSR_TCFG, ALL, 32'h0, '0, 1'b0);
        add_step(OP_WR, CSR_TICLR, ALL, 32'h0000_0001, '0, 1'b0);
        add_step(OP_RD, CSR_ESTAT, ALL, '0, 32'h694B_0000, 1'b0);
        add_step(OP_RD, CSR_TVAL, ALL, '0, 32'h0000_0001, 1'b0);
        // Interrupt request toggled one factor at a time
        add_step(OP_WR, CSR_ESTAT, ALL, ALL, '0, 1'b0);
        add_step(OP_RD, CSR_ESTAT, ALL, '0, 32'h694B_0003, 1'b0);
        add_step(OP_WR, CSR_ECFG, ALL, 32'h0000_0002, '0, 1'b0);
        add_step(OP_RD, CSR_ECFG, ALL, '0, 32'h0000_0002, 1'b1);
        add_step(OP_WR, CSR_CRMD, 32'h0000_0004, 32'h0, '0, 1'b0);
        add_step(OP_RD, CSR_CRMD, ALL, '0, 32'h0000_000B, 1'b0);
        add_step(OP_WR, CSR_CRMD, 32'h0000_0004, 32'h0000_0004, '0, 1'b0);
        add_step(OP_RD, CSR_CRMD, ALL, '0, 32'h0000_000F, 1'b1);
        add_step(OP_WR, CSR_ESTAT, 32'h0000_0003, 32'h0, '0, 1'b0);
        add_step(OP_RD, CSR_ESTAT, ALL, '0, 32'h694B_0000, 1'b0);
        add_step(OP_WR, CSR_ECFG, ALL, 32'h0000_0800, '0, 1'b0);
        add_step(OP_RD, CSR_ECFG, ALL, '0, 32'h0000_0800, 1'b0);
        add_step(OP_WR, CSR_TCFG, ALL, 32'h0000_0005, '0, 1'b0);
        add_step(OP_PINT, CSR_ESTAT, 32'h0000_0800, '0, 32'h0000_0800, 1'b1);
        add_step(OP_WR, CSR_TICLR, ALL, 32'h0000_0001, '0, 1'b0);
        add_step(OP_RD, CSR_ESTAT, ALL, '0, 32'h694B_0000, 1'b0);
    endfunction

    function automatic logic condition_met(step_t s);
        if (s.op == OP_PINT)
            return has_int === s.want_int;
        return (csr_rdata & s.mask) === (s.want & s.mask);
    endfunction

    task automatic arm_check(input int idx, input step_t s);
        csr_raddr = s.addr;
        step_no   = idx;
        kind      = (s.op == OP_ENT) ? 2'd1 : (s.op == OP_RET) ? 2'd2 : 2'd0;
        want      = s.want;
        want_mask = s.mask;
        want_int  = s.want_int;
        check     = 1'b1;
    endtask

    // Entered and left 1 ns after a rising edge
    task automatic apply_step(input int idx, input step_t s);
        int   waited;
        logic hit;
        waited     = 0;
        csr_we     = 1'b0;
        wb_exc     = 1'b0;
        ertn_flush = 1'b0;
        check      = 1'b0;
        case (s.op)
            OP_WR: begin
                csr_we    = 1'b1;
                csr_waddr = s.addr;
                csr_wmask = s.mask;
                csr_wdata = s.data;
            end
            OP_EXC: begin
                wb_exc      = 1'b1;
                wb_esubcode = s.code[14:6];
                wb_ecode    = s.code[5:0];
                wb_pc       = s.pc;
            end
            OP_ERTN: ertn_flush = 1'b1;
            OP_IDLE: begin
                repeat (s.data - 1) begin
                    @(posedge clk);
                    #1;
                end
            end
            OP_POLL, OP_PINT: begin
                csr_raddr = s.addr;
                @(negedge clk);
                hit = condition_met(s);
                while (!hit && waited < POLL_LIMIT) begin
                    @(negedge clk);
                    waited++;
                    hit = condition_met(s);
                end
                @(posedge clk);
                #1;
                if (hit) begin
                    arm_check(idx, s);
                end else begin
                    timeouts++;
                    $display("Timeout at %0t: step %0d gave up after %0d cycles of polling",
                             $time, idx, POLL_LIMIT);
                end
            end
            default: arm_check(idx, s);
        endcase
        @(posedge clk);
        #1;
    endtask

    initial begin
        resetn      = 1'b0;
        csr_we      = 1'b0;
        csr_waddr   = '0;
        csr_wmask   = '0;
        csr_wdata   = '0;
        csr_raddr   = '0;
        wb_exc      = 1'b0;
        wb_ecode    = '0;
        wb_esubcode = '0;
        wb_pc       = '0;
        ertn_flush  = 1'b0;
        check       = 1'b0;
        kind        = 2'd0;
        step_no     = 0;
        want        = '0;
        want_mask   = '0;
        want_int    = 1'b0;
        void'($urandom(SEED));
        build_table();
        repeat (2) @(posedge clk);
        #1;
        resetn = 1'b1;
        foreach (steps[i])
            apply_step(i, steps[i]);
        check = 1'b0;
        $display("Totals: %0d checks passed, %0d failed, %0d timeouts",
                 passes, fails, timeouts);
        if (fails == 0 && timeouts == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// File: bench/csr_checker.sv
`timescale 1ns/10ps

module csr_checker import csr_pkg::*; (
    input  logic       clk,
    input  logic       check,
    input  logic [1:0] kind,
    input  int         step_no,
    input  csr_word_t  want,
    input  csr_word_t  want_mask,
    input  logic       want_int,
    input  csr_word_t  rdata,
    input  csr_word_t  entaddr,
    input  csr_word_t  retaddr,
    input  logic       has_int,
    output int         passes,
    output int         fails
);

    int        pass_n = 0;
    int        fail_n = 0;
    csr_word_t got;

    // Kinds 1 and 2 look at the exception vectors instead of the read port
    always_comb begin
        case (kind)
            2'd1:    got = entaddr;
            2'd2:    got = retaddr;
            default: got = rdata;
        endcase
    end

    function automatic string source_name(logic [1:0] k);
        case (k)
            2'd1:    return "exc_entaddr";
            2'd2:    return "exc_retaddr";
            default: return "csr_rdata";
        endcase
    endfunction

    // Sampled at the falling edge while the inputs are stable
    always @(negedge clk) begin
        if (check) begin
            if ((got & want_mask) !== (want & want_mask) || has_int !== want_int) begin
                fail_n = fail_n + 1;
                $display("Error at %0t: step %0d %s=%h want %h mask %h has_int=%b want %b",
                         $time, step_no, source_name(kind), got, want, want_mask,
                         has_int, want_int);
            end else begin
                pass_n = pass_n + 1;
                $display("ok at %0t: step %0d %s = %h, has_int %b",
                         $time, step_no, source_name(kind), got, has_int);
            end
        end
    end

    assign passes = pass_n;
    assign fails  = fail_n;

endmodule

// File: hw/csr_regfile.sv
`timescale 1ns/10ps

module csr_regfile import csr_pkg::*; (
    input  logic                  clk,
    input  logic                  resetn,

    input  logic                  csr_we,
    input  logic [CSR_ADDR_W-1:0] csr_waddr,
    input  csr_word_t             csr_wmask,
    input  csr_word_t             csr_wdata,

    input  logic [CSR_ADDR_W-1:0] csr_raddr,
    output csr_word_t             csr_rdata,

    input  logic                  wb_exc,
    input  logic [ECODE_W-1:0]    wb_ecode,
    input  logic [ESUBCODE_W-1:0] wb_esubcode,
    input  csr_word_t             wb_pc,
    input  logic                  ertn_flush,

    output logic                  has_int,
    output csr_word_t             exc_entaddr,
    output csr_word_t             exc_retaddr
);

    csr_wr_if wr_bus ();

    exc_view_t   exc_view;
    timer_view_t tmr_view;
    csr_word_t   save_words [SAVE_COUNT];

    assign wr_bus.we    = csr_we;
    assign wr_bus.waddr = csr_waddr;
    assign wr_bus.wmask = csr_wmask;
    assign wr_bus.wdata = csr_wdata;

    csr_exc_state i_exc_state (
        .clk         (clk),
        .resetn      (resetn),
        .wr          (wr_bus.sink),
        .wb_exc      (wb_exc),
        .ertn_flush  (ertn_flush),
        .wb_ecode    (wb_ecode),
        .wb_esubcode (wb_esubcode),
        .wb_pc       (wb_pc),
        .ti_pending  (tmr_view.ti_pending),
        .view        (exc_view),
        .has_int     (has_int)
    );

    csr_timer i_timer (
        .clk    (clk),
        .resetn (resetn),
        .wr     (wr_bus.sink),
        .view   (tmr_view)
    );

    for (genvar i = 0; i < SAVE_COUNT; i++) begin : g_save
        csr_save_slot #(
            .SLOT_ADDR (CSR_SAVE_BASE + CSR_ADDR_W'(i))
        ) i_save_slot (
            .clk    (clk),
            .resetn (resetn),
            .wr     (wr_bus.sink),
            .value  (save_words[i])
        );
    end

    csr_read_mux i_read_mux (
        .raddr (csr_raddr),
        .exc   (exc_view),
        .tmr   (tmr_view),
        .save  (save_words),
        .rdata (csr_rdata)
    );

    // Entry vector has its low six bits zero
    assign exc_entaddr = {exc_view.eentry_va, {EENTRY_VA_LSB{1'b0}}};
    assign exc_retaddr = exc_view.era;

endmodule

// File: hw/csr_read_mux.sv
`timescale 1ns/10ps

module csr_read_mux import csr_pkg::*; (
    input  logic [CSR_ADDR_W-1:0] raddr,
    input  exc_view_t             exc,
    input  timer_view_t           tmr,
    input  csr_word_t             save [SAVE_COUNT],
    output csr_word_t             rdata
);

    csr_word_t crmd_word, prmd_word, ecfg_word, estat_word, eentry_word, tcfg_word;
    logic [CSR_ADDR_W-1:0] save_off;

    assign save_off = raddr - CSR_SAVE_BASE;

    always_comb begin
        crmd_word = '0;
        crmd_word[CRMD_PLV_LSB +: PLV_W] = exc.crmd_plv;
        crmd_word[CRMD_IE_BIT] = exc.crmd_ie;
        crmd_word[CRMD_DA_BIT] = 1'b1;
        crmd_word[CRMD_PG_BIT] = 1'b0;

        prmd_word = '0;
        prmd_word[PRMD_PPLV_LSB +: PLV_W] = exc.prmd_pplv;
        prmd_word[PRMD_PIE_BIT] = exc.prmd_pie;

        ecfg_word = '0;
        ecfg_word[ECFG_LIE_LSB +: LIE_W] = exc.ecfg_lie;

        // Hardware and IPI lines are not wired and read 0
        estat_word = '0;
        estat_word[ESTAT_IS_LSB +: 2] = exc.estat_is_sw;
        estat_word[ESTAT_IS_LSB + TI_BIT] = tmr.ti_pending;
        estat_word[ESTAT_ECODE_LSB +: ECODE_W] = exc.ecode;
        estat_word[ESTAT_ESUBCODE_LSB +: ESUBCODE_W] = exc.esubcode;

        eentry_word = '0;
        eentry_word[EENTRY_VA_LSB +: EENTRY_VA_W] = exc.eentry_va;

        tcfg_word = '0;
        tcfg_word[TCFG_EN_BIT] = tmr.tcfg_en;
        tcfg_word[TCFG_PERIODIC_BIT] = tmr.tcfg_periodic;
        tcfg_word[TCFG_INITVAL_LSB +: TIMER_INIT_W] = tmr.tcfg_initval;

        rdata = '0;
        case (raddr)
            CSR_CRMD:   rdata = crmd_word;
            CSR_PRMD:   rdata = prmd_word;
            CSR_ECFG:   rdata = ecfg_word;
            CSR_ESTAT:  rdata = estat_word;
            CSR_ERA:    rdata = exc.era;
            CSR_EENTRY: rdata = eentry_word;
            CSR_TCFG:   rdata = tcfg_word;
            CSR_TVAL:   rdata = tmr.tval;
            default: begin
                // Offset wraps high below the base so one compare covers the range
                if (save_off < CSR_ADDR_W'(SAVE_COUNT))
                    rdata = save[save_off[SAVE_IDX_W-1:0]];
            end
        endcase
    end

endmodule

// File: hw/csr_save_slot.sv
`timescale 1ns/10ps

module csr_save_slot import csr_pkg::*; #(
    parameter logic [CSR_ADDR_W-1:0] SLOT_ADDR = CSR_SAVE_BASE
) (
    input  logic   clk,
    input  logic   resetn,
    csr_wr_if.sink wr,
    output csr_word_t value
);

    logic slot_we;

    assign slot_we = wr.we && (wr.waddr == SLOT_ADDR);

    always_ff @(posedge clk) begin
        if (!resetn)
            value <= '0;
        else if (slot_we)
            value <= csr_merge(value, wr.wdata, wr.wmask);
    end

endmodule

// File: hw/csr_timer.sv
`timescale 1ns/10ps

module csr_timer import csr_pkg::*; (
    input  logic        clk,
    input  logic        resetn,
    csr_wr_if.sink      wr,
    output timer_view_t view
);

    logic                    tcfg_en;
    logic                    tcfg_periodic;
    logic [TIMER_INIT_W-1:0] tcfg_initval;
    csr_word_t               tval;
    logic                    ti_pending;

    csr_word_t tcfg_old;
    csr_word_t tcfg_new;
    logic      tcfg_we;
    logic      ticlr_clr;
    logic      expired;

    assign tcfg_we = wr.we && (wr.waddr == CSR_TCFG);
    assign ticlr_clr = wr.we && (wr.waddr == CSR_TICLR)
                       && wr.wmask[TICLR_CLR_BIT] && wr.wdata[TICLR_CLR_BIT];

    always_comb begin
        tcfg_old = '0;
        tcfg_old[TCFG_EN_BIT] = tcfg_en;
        tcfg_old[TCFG_PERIODIC_BIT] = tcfg_periodic;
        tcfg_old[TCFG_INITVAL_LSB +: TIMER_INIT_W] = tcfg_initval;
    end

    // The load decision looks at the value the write is about to produce
    assign tcfg_new = csr_merge(tcfg_old, wr.wdata, wr.wmask);
    assign expired = tcfg_en && (tval == '0);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            tcfg_en       <= 1'b0;
            tcfg_periodic <= 1'b0;
            tcfg_initval  <= '0;
        end else if (tcfg_we) begin
            tcfg_en       <= tcfg_new[TCFG_EN_BIT];
            tcfg_periodic <= tcfg_new[TCFG_PERIODIC_BIT];
            tcfg_initval  <= tcfg_new[TCFG_INITVAL_LSB +: TIMER_INIT_W];
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            tval <= TIMER_IDLE;
        end else if (tcfg_we && tcfg_new[TCFG_EN_BIT]) begin
            tval <= {tcfg_new[TCFG_INITVAL_LSB +: TIMER_INIT_W], 2'b00};
        end else if (tcfg_en && (tval != TIMER_IDLE)) begin
            if (tval == '0 && tcfg_periodic)
                tval <= {tcfg_initval, 2'b00};
            else
                tval <= tval - 1'b1;  // one-shot wraps to idle
        end
    end

    // Set wins over a TICLR clear in the same cycle
    always_ff @(posedge clk) begin
        if (!resetn)
            ti_pending <= 1'b0;
        else if (expired)
            ti_pending <= 1'b1;
        else if (ticlr_clr)
            ti_pending <= 1'b0;
    end

    assign view.tcfg_en       = tcfg_en;
    assign view.tcfg_periodic = tcfg_periodic;
    assign view.tcfg_initval  = tcfg_initval;
    assign view.tval          = tval;
    assign view.ti_pending    = ti_pending;

endmodule

// File: hw/csr_exc_state.sv
`timescale 1ns/10ps

module csr_exc_state import csr_pkg::*; (
    input  logic                  clk,
    input  logic                  resetn,
    csr_wr_if.sink                wr,
    input  logic                  wb_exc,
    input  logic                  ertn_flush,
    input  logic [ECODE_W-1:0]    wb_ecode,
    input  logic [ESUBCODE_W-1:0] wb_esubcode,
    input  csr_word_t             wb_pc,
    input  logic                  ti_pending,
    output exc_view_t             view,
    output logic                  has_int
);

    logic [PLV_W-1:0]       crmd_plv;
    logic                   crmd_ie;
    logic [PLV_W-1:0]       prmd_pplv;
    logic                   prmd_pie;
    logic [LIE_W-1:0]       ecfg_lie;
    logic [1:0]             estat_is_sw;
    logic [ECODE_W-1:0]     estat_ecode;
    logic [ESUBCODE_W-1:0]  estat_esubcode;
    csr_word_t              era;
    logic [EENTRY_VA_W-1:0] eentry_va;

    csr_word_t crmd_old, prmd_old, ecfg_old, estat_old, eentry_old;
    csr_word_t crmd_new, prmd_new, ecfg_new, estat_new, era_new, eentry_new;
    logic      crmd_we, prmd_we, ecfg_we, estat_we, era_we, eentry_we;
    logic [TI_BIT:0] int_pending;

    assign crmd_we   = wr.we && (wr.waddr == CSR_CRMD);
    assign prmd_we   = wr.we && (wr.waddr == CSR_PRMD);
    assign ecfg_we   = wr.we && (wr.waddr == CSR_ECFG);
    assign estat_we  = wr.we && (wr.waddr == CSR_ESTAT);
    assign era_we    = wr.we && (wr.waddr == CSR_ERA);
    assign eentry_we = wr.we && (wr.waddr == CSR_EENTRY);

    // Place the writable fields back at their architectural bits
    always_comb begin
        crmd_old = '0;
        crmd_old[CRMD_PLV_LSB +: PLV_W] = crmd_plv;
        crmd_old[CRMD_IE_BIT] = crmd_ie;
        prmd_old = '0;
        prmd_old[PRMD_PPLV_LSB +: PLV_W] = prmd_pplv;
        prmd_old[PRMD_PIE_BIT] = prmd_pie;
        ecfg_old = '0;
        ecfg_old[ECFG_LIE_LSB +: LIE_W] = ecfg_lie;
        estat_old = '0;
        estat_old[ESTAT_IS_LSB +: 2] = estat_is_sw;
        eentry_old = '0;
        eentry_old[EENTRY_VA_LSB +: EENTRY_VA_W] = eentry_va;
    end

    assign crmd_new   = csr_merge(crmd_old, wr.wdata, wr.wmask);
    assign prmd_new   = csr_merge(prmd_old, wr.wdata, wr.wmask);
    assign ecfg_new   = csr_merge(ecfg_old, wr.wdata, wr.wmask);
    assign estat_new  = csr_merge(estat_old, wr.wdata, wr.wmask);
    assign era_new    = csr_merge(era, wr.wdata, wr.wmask);
    assign eentry_new = csr_merge(eentry_old, wr.wdata, wr.wmask);

    // Entry beats return and return beats a CSR write
    always_ff @(posedge clk) begin
        if (!resetn) begin
            crmd_plv <= '0;
            crmd_ie  <= 1'b0;
        end else if (wb_exc) begin
            crmd_plv <= '0;
            crmd_ie  <= 1'b0;
        end else if (ertn_flush) begin
            crmd_plv <= prmd_pplv;
            crmd_ie  <= prmd_pie;
        end else if (crmd_we) begin
            crmd_plv <= crmd_new[CRMD_PLV_LSB +: PLV_W];
            crmd_ie  <= crmd_new[CRMD_IE_BIT];
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            prmd_pplv <= '0;
            prmd_pie  <= 1'b0;
        end else if (wb_exc) begin
            prmd_pplv <= crmd_plv;
            prmd_pie  <= crmd_ie;
        end else if (prmd_we) begin
            prmd_pplv <= prmd_new[PRMD_PPLV_LSB +: PLV_W];
            prmd_pie  <= prmd_new[PRMD_PIE_BIT];
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            ecfg_lie       <= '0;
            estat_is_sw    <= '0;
            estat_ecode    <= '0;
            estat_esubcode <= '0;
            era            <= '0;
            eentry_va      <= '0;
        end else begin
            if (ecfg_we)
                ecfg_lie <= ecfg_new[ECFG_LIE_LSB +: LIE_W];
            if (estat_we)
                estat_is_sw <= estat_new[ESTAT_IS_LSB +: 2];
            if (wb_exc) begin
                estat_ecode    <= wb_ecode;
                estat_esubcode <= wb_esubcode;
            end
            if (wb_exc)
                era <= wb_pc;
            else if (era_we)
                era <= era_new;
            if (eentry_we)
                eentry_va <= eentry_new[EENTRY_VA_LSB +: EENTRY_VA_W];
        end
    end

    // Software lines at 1:0 and timer line at TI_BIT
    always_comb begin
        int_pending = '0;
        int_pending[1:0] = estat_is_sw;
        int_pending[TI_BIT] = ti_pending;
    end

    assign has_int = (|(int_pending & ecfg_lie[TI_BIT:0])) && crmd_ie;

    assign view.crmd_plv    = crmd_plv;
    assign view.crmd_ie     = crmd_ie;
    assign view.prmd_pplv   = prmd_pplv;
    assign view.prmd_pie    = prmd_pie;
    assign view.ecfg_lie    = ecfg_lie;
    assign view.estat_is_sw = estat_is_sw;
    assign view.ecode       = estat_ecode;
    assign view.esubcode    = estat_esubcode;
    assign view.era         = era;
    assign view.eentry_va   = eentry_va;

endmodule

// File: hw/csr_wr_if.sv
`timescale 1ns/10ps

interface csr_wr_if import csr_pkg::*; ();

    logic                  we;
    logic [CSR_ADDR_W-1:0] waddr;
    csr_word_t             wmask;
    csr_word_t             wdata;

    modport source (
        output we,
        output waddr,
        output wmask,
        output wdata
    );

    modport sink (
        input we,
        input waddr,
        input wmask,
        input wdata
    );

endinterface

// File: hw/csr_pkg.sv
package csr_pkg;

    localparam int CSR_ADDR_W = 14;
    localparam int CSR_DATA_W = 32;

    typedef logic [CSR_DATA_W-1:0] csr_word_t;

    // Register addresses
    localparam logic [CSR_ADDR_W-1:0] CSR_CRMD      = 14'h00;
    localparam logic [CSR_ADDR_W-1:0] CSR_PRMD      = 14'h01;
    localparam logic [CSR_ADDR_W-1:0] CSR_ECFG      = 14'h04;
    localparam logic [CSR_ADDR_W-1:0] CSR_ESTAT     = 14'h05;
    localparam logic [CSR_ADDR_W-1:0] CSR_ERA       = 14'h06;
    localparam logic [CSR_ADDR_W-1:0] CSR_EENTRY    = 14'h0C;
    localparam logic [CSR_ADDR_W-1:0] CSR_SAVE_BASE = 14'h30;
    localparam logic [CSR_ADDR_W-1:0] CSR_TCFG      = 14'h41;
    localparam logic [CSR_ADDR_W-1:0] CSR_TVAL      = 14'h42;
    localparam logic [CSR_ADDR_W-1:0] CSR_TICLR     = 14'h44;

    localparam int SAVE_COUNT = 4;
    localparam int SAVE_IDX_W = $clog2(SAVE_COUNT);

    // Field widths
    localparam int PLV_W        = 2;
    localparam int LIE_W        = 13;
    localparam int ECODE_W      = 6;
    localparam int ESUBCODE_W   = 9;
    localparam int EENTRY_VA_W  = 26;
    localparam int TIMER_INIT_W = 30;

    // Field positions
    localparam int CRMD_PLV_LSB       = 0;
    localparam int CRMD_IE_BIT        = 2;
    localparam int CRMD_DA_BIT        = 3;
    localparam int CRMD_PG_BIT        = 4;
    localparam int PRMD_PPLV_LSB      = 0;
    localparam int PRMD_PIE_BIT       = 2;
    localparam int ECFG_LIE_LSB       = 0;
    localparam int ESTAT_IS_LSB       = 0;
    localparam int ESTAT_ECODE_LSB    = 16;
    localparam int ESTAT_ESUBCODE_LSB = 22;
    localparam int EENTRY_VA_LSB      = 6;
    localparam int TCFG_EN_BIT        = 0;
    localparam int TCFG_PERIODIC_BIT  = 1;
    localparam int TCFG_INITVAL_LSB   = 2;
    localparam int TICLR_CLR_BIT      = 0;

    // Counter parks here once a one-shot period has expired
    localparam csr_word_t TIMER_IDLE = '1;

    localparam int TI_BIT = 11;

    typedef struct packed {
        logic [PLV_W-1:0]       crmd_plv;
        logic                   crmd_ie;
        logic [PLV_W-1:0]       prmd_pplv;
        logic                   prmd_pie;
        logic [LIE_W-1:0]       ecfg_lie;
        logic [1:0]             estat_is_sw;
        logic [ECODE_W-1:0]     ecode;
        logic [ESUBCODE_W-1:0]  esubcode;
        csr_word_t              era;
        logic [EENTRY_VA_W-1:0] eentry_va;
    } exc_view_t;

    typedef struct packed {
        logic                    tcfg_en;
        logic                    tcfg_periodic;
        logic [TIMER_INIT_W-1:0] tcfg_initval;
        csr_word_t               tval;
        logic                    ti_pending;
    } timer_view_t;

    // Bitwise merge of a masked write into an old register word
    function automatic csr_word_t csr_merge(csr_word_t old_val, csr_word_t wdata,
                                            csr_word_t wmask);
        return (wdata & wmask) | (old_val & ~wmask);
    endfunction

endpackage
